//--- avmm_dcg_config.svh
// bus and register bank sizes for the gated AVMM config block
// the CSR depth must equal 2**AVMM_ADDR_W because the address is not range checked
`ifndef AVMM_DCG_CONFIG_SVH
`define AVMM_DCG_CONFIG_SVH

// ******************************
// bus widths
// ******************************

// register word address, no byte lanes
`define AVMM_ADDR_W 4

// single word data path
`define AVMM_DATA_W 32

// ******************************
// register bank and gating
// ******************************

// one register per address
`define AVMM_CSR_DEPTH 16

// idle counter and wait count width
// the testbus layout follows from this plus four flag bits
`define DCG_CNT_W 4

`endif

//--- avmm_dcg_pkg.sv
// shared types for the gated AVMM config block
// the register reset value applies to every entry of the bank
`include "avmm_dcg_config.svh"

package avmm_dcg_pkg;

  // ******************************
  // clock gating state
  // ******************************

  // one bit, matches the state bit on the testbus
  typedef enum logic
  {
    UNGATED = 1'b0,
    GATED   = 1'b1
  } dcg_state_e;

  // ******************************
  // register bank
  // ******************************

  // value loaded into every CSR during reset
  localparam logic [`AVMM_DATA_W-1:0] csr_reset_val = '0;

endpackage

//--- avmm_req_if.sv
// one captured AVMM request, held stable until the bank acknowledges it
// capture side runs on clk, bank side on the gated clock of the same source
`timescale 1ns/100ps
`include "avmm_dcg_config.svh"

interface avmm_req_if;

  // request held by the capture stage
  logic                    req_valid;
  // 1 = write, 0 = read
  logic                    req_write;
  logic [`AVMM_ADDR_W-1:0] req_address;
  logic [`AVMM_DATA_W-1:0] req_writedata;

  // one gated cycle pulse from the bank
  logic                    req_done;

  // input side owns the request fields
  modport capture
  (
    output req_valid,
    output req_write,
    output req_address,
    output req_writedata,
    input  req_done
  );

  // register bank consumes them and acknowledges
  modport bank
  (
    input  req_valid,
    input  req_write,
    input  req_address,
    input  req_writedata,
    output req_done
  );

endinterface

//--- avmm_req_capture.sv
// accepts one read or write strobe at a time, strobes during busy are dropped
// no waitrequest, the master must watch busy
`timescale 1ns/100ps
`include "avmm_dcg_config.svh"

module avmm_req_capture
(
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    read,
  input  logic                    write,
  input  logic [`AVMM_ADDR_W-1:0] address,
  input  logic [`AVMM_DATA_W-1:0] writedata,
  input  logic                    rd_done,
  avmm_req_if.capture             req,
  output logic                    ungate,
  output logic                    gate,
  output logic                    busy
);

  // ******************************
  // request tracking
  // ******************************

  // request still waiting for the bank
  logic req_held;
  // read issued, data not yet returned
  logic rd_pend;
  // new strobe taken this cycle
  logic accept;

  assign accept = (read | write) & ~busy;

  // control state
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      req_held <= 1'b0;
      rd_pend  <= 1'b0;
    end
    else
    begin
      // hold until the bank pulses done
      if (accept)
        req_held <= 1'b1;
      else if (req.req_done)
        req_held <= 1'b0;

      // write wins if both strobes come together
      if (accept && !write)
        rd_pend <= 1'b1;
      else if (rd_done)
        rd_pend <= 1'b0;
    end
  end

  // request payload, loaded only on accept
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      req.req_write     <= write;
      req.req_address   <= address;
      req.req_writedata <= writedata;
    end
  end

  assign req.req_valid = req_held;

  // ******************************
  // gating demands
  // ******************************

  // held request needs the gated clock running
  assign ungate = req_held;
  // nothing in flight, clock may stop
  assign gate   = ~req_held & ~rd_pend;
  assign busy   = req_held | rd_pend;

endmodule

//--- avmmclk_dcg.sv
// dynamic clock gating for the AVMM register clock, te forces the raw clock
// state is UNGATED during reset so logic on gclk still sees the reset
`timescale 1ns/100ps
`include "avmm_dcg_config.svh"

module avmmclk_dcg
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   ungate,
  input  logic                   gate,
  input  logic                   dcg_en,
  input  logic                   dcg_cnt_bypass,
  input  logic [`DCG_CNT_W-1:0]  dcg_wait_cnt,
  input  logic                   te,
  output logic                   gclk,
  output logic [`DCG_CNT_W+3:0]  dcg_testbus
);

  import avmm_dcg_pkg::*;

  dcg_state_e            state_q;
  dcg_state_e            state_d;
  logic [`DCG_CNT_W-1:0] cnt_q;
  logic                  cnt_timeout;
  logic                  idle;
  logic                  ungated_s;
  logic                  gated_s;
  logic                  dcg_clken;
  logic                  clken_lat;
  logic                  gated_clk;

  assign ungated_s = (state_q == UNGATED);
  assign gated_s   = (state_q == GATED);

  // enabled, no request and nothing pending
  assign idle = dcg_en & ~ungate & gate;

  // clken, state, counter, gate, ungate
  assign dcg_testbus = {dcg_clken, state_q, cnt_q, gate, ungate};

  // ******************************
  // idle counter
  // ******************************

  // counts only while ungated and idle
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      cnt_q <= '0;
    else if (idle && ungated_s)
      cnt_q <= cnt_q + 1'b1;
    else
      cnt_q <= '0;
  end

  // wait count N gives N+1 idle cycles
  assign cnt_timeout = (cnt_q == dcg_wait_cnt);

  // ******************************
  // gating FSM
  // ******************************

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      state_q <= UNGATED;
    else
      state_q <= state_d;
  end

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      UNGATED:
      begin
        // bypass skips the wait
        if (idle && (dcg_cnt_bypass || cnt_timeout))
          state_d = GATED;
      end
      GATED:
      begin
        // wake in the strobe's own cycle
        if (!dcg_en || ungate)
          state_d = UNGATED;
      end
      default:
      begin
        state_d = UNGATED;
      end
    endcase
  end

  // ******************************
  // clock gate and scan mux
  // ******************************

  // ungate acts combinationally so the next edge is not lost
  assign dcg_clken = ungated_s | (gated_s & (~dcg_en | ungate));

  // transparent while clk low, no glitch on gated_clk
  always_latch
  begin
    if (!clk)
      clken_lat = dcg_clken;
  end

  assign gated_clk = clk & clken_lat;

  // scan mode passes the free running clock
  assign gclk = te ? clk : gated_clk;

endmodule

//--- avmm_csr_bank.sv
// register file on the gated clock, one access per held request
// reset only takes effect while gclk runs, which the DCG state guarantees
`timescale 1ns/100ps
`include "avmm_dcg_config.svh"

module avmm_csr_bank
(
  input  logic                    gclk,
  input  logic                    rst_n,
  avmm_req_if.bank                req,
  output logic [`AVMM_DATA_W-1:0] rd_data,
  output logic                    rd_done
);

  import avmm_dcg_pkg::*;

  logic [`AVMM_DATA_W-1:0] regs [`AVMM_CSR_DEPTH];
  logic                    req_done_q;
  // new request not yet acknowledged
  logic                    fire;
  logic                    wr_fire;
  logic                    rd_fire;

  // done is still high on the second edge, so the access runs once
  assign fire    = req.req_valid & ~req_done_q;
  assign wr_fire = fire & req.req_write;
  assign rd_fire = fire & ~req.req_write;

  // ******************************
  // handshake pulses
  // ******************************

  always_ff @(posedge gclk)
  begin
    if (!rst_n)
    begin
      req_done_q <= 1'b0;
      rd_done    <= 1'b0;
    end
    else
    begin
      // one cycle each
      req_done_q <= fire;
      rd_done    <= rd_fire;
    end
  end

  assign req.req_done = req_done_q;

  // ******************************
  // register storage
  // ******************************

  always_ff @(posedge gclk)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < `AVMM_CSR_DEPTH; i++)
        regs[i] <= csr_reset_val;
    end
    else if (wr_fire)
    begin
      regs[req.req_address] <= req.req_writedata;
    end
  end

  // read port, valid together with rd_done
  always_ff @(posedge gclk)
  begin
    if (rd_fire)
      rd_data <= regs[req.req_address];
  end

endmodule

//--- avmm_resp_drive.sv
// returns read data on the free running clock one cycle after rd_done
// readdata keeps the last read value between responses
`timescale 1ns/100ps
`include "avmm_dcg_config.svh"

module avmm_resp_drive
(
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic [`AVMM_DATA_W-1:0] rd_data,
  input  logic                    rd_done,
  output logic [`AVMM_DATA_W-1:0] readdata,
  output logic                    readdatavalid
);

  // ******************************
  // response register
  // ******************************

  // gclk and clk share a source, plain retiming is enough
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      readdatavalid <= 1'b0;
      readdata      <= '0;
    end
    else
    begin
      // one pulse per read
      readdatavalid <= rd_done;

      // hold until the next read result
      if (rd_done)
        readdata <= rd_data;
    end
  end

endmodule

//--- avmm_dcg_top.sv
// AVMM config slave with dynamic clock gating, single word strobes only
// do not strobe while busy, reads return two cycles after the strobe
`timescale 1ns/100ps
`include "avmm_dcg_config.svh"

module avmm_dcg_top
(
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    read,
  input  logic                    write,
  input  logic [`AVMM_ADDR_W-1:0] address,
  input  logic [`AVMM_DATA_W-1:0] writedata,
  input  logic                    dcg_en,
  input  logic                    dcg_cnt_bypass,
  input  logic [`DCG_CNT_W-1:0]   dcg_wait_cnt,
  input  logic                    te,
  output logic [`AVMM_DATA_W-1:0] readdata,
  output logic                    readdatavalid,
  output logic                    busy,
  output logic                    gclk,
  output logic [`DCG_CNT_W+3:0]   dcg_testbus
);

  logic                    ungate;
  logic                    gate;
  logic [`AVMM_DATA_W-1:0] rd_data;
  logic                    rd_done;

  // request path between capture and bank
  avmm_req_if req_bus ();

  // ******************************
  // free running side
  // ******************************

  avmm_req_capture u_capture
  (
    .clk       (clk),
    .rst_n     (rst_n),
    .read      (read),
    .write     (write),
    .address   (address),
    .writedata (writedata),
    .rd_done   (rd_done),
    .req       (req_bus.capture),
    .ungate    (ungate),
    .gate      (gate),
    .busy      (busy)
  );

  // gclk also leaves the block for other register slices
  avmmclk_dcg u_dcg
  (
    .clk            (clk),
    .rst_n          (rst_n),
    .ungate         (ungate),
    .gate           (gate),
    .dcg_en         (dcg_en),
    .dcg_cnt_bypass (dcg_cnt_bypass),
    .dcg_wait_cnt   (dcg_wait_cnt),
    .te             (te),
    .gclk           (gclk),
    .dcg_testbus    (dcg_testbus)
  );

  // ******************************
  // gated side and response
  // ******************************

  avmm_csr_bank u_csr_bank
  (
    .gclk    (gclk),
    .rst_n   (rst_n),
    .req     (req_bus.bank),
    .rd_data (rd_data),
    .rd_done (rd_done)
  );

  avmm_resp_drive u_resp
  (
    .clk           (clk),
    .rst_n         (rst_n),
    .rd_data       (rd_data),
    .rd_done       (rd_done),
    .readdata      (readdata),
    .readdatavalid (readdatavalid)
  );

endmodule

//--- avmm_dcg_assertions.sv
// port level checks for avmm_dcg_top, attached to every instance by bind
// the state bit position follows the testbus layout of the DCG block
`timescale 1ns/100ps
`include "avmm_dcg_config.svh"

module avmm_dcg_assertions
(
  input logic                    clk,
  input logic                    rst_n,
  input logic                    read,
  input logic                    write,
  input logic                    busy,
  input logic [`AVMM_DATA_W-1:0] readdata,
  input logic                    readdatavalid,
  input logic [`DCG_CNT_W+3:0]   dcg_testbus
);

  // state sits just above the counter
  localparam int st_bit = `DCG_CNT_W + 2;

  // failed assertions so far
  int assert_errs = 0;

  // ******************************
  // response side
  // ******************************

  // one pulse per read
  rdv_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    readdatavalid |=> !readdatavalid)
    else
    begin
      $error("readdatavalid high for more than one cycle");
      assert_errs++;
    end

  // data only moves together with the valid pulse
  rdata_stable: assert property (@(posedge clk) disable iff (!rst_n)
    !readdatavalid |-> $stable(readdata))
    else
    begin
      $error("readdata changed without readdatavalid");
      assert_errs++;
    end

  // ******************************
  // request side and gating
  // ******************************

  // no waitrequest, so a strobe during busy would be lost
  no_strobe_busy: assert property (@(posedge clk) disable iff (!rst_n)
    busy |-> !(read || write))
    else
    begin
      $error("read or write strobe while busy");
      assert_errs++;
    end

  // gclk must keep running while reset is applied
  ungated_in_reset: assert property (@(posedge clk)
    !rst_n |=> !dcg_testbus[st_bit])
    else
    begin
      $error("DCG state not UNGATED during reset");
      assert_errs++;
    end

endmodule

bind avmm_dcg_top avmm_dcg_assertions u_checks
(
  .clk           (clk),
  .rst_n         (rst_n),
  .read          (read),
  .write         (write),
  .busy          (busy),
  .readdata      (readdata),
  .readdatavalid (readdatavalid),
  .dcg_testbus   (dcg_testbus)
);

//--- tb_avmm_dcg.sv
// self checking testbench for the gated AVMM config block, one access at a time
// inputs change on the falling edge, outputs are sampled at the falling edge
`timescale 1ns/100ps
`include "avmm_dcg_config.svh"

module tb_avmm_dcg;

  localparam int op_write = 0;
  localparam int op_read  = 1;
  localparam int op_idle  = 2;
  localparam int op_scan  = 3;
  localparam int st_bit   = `DCG_CNT_W + 2;

  // one row of the stimulus table
  typedef struct packed
  {
    int op;
    int addr;
    int cycles;
    bit en;
    bit byp;
    int wcnt;
    bit te;
    int exp;
  } entry_t;

  logic                    clk;
  logic                    rst_n;
  logic                    read;
  logic                    write;
  logic [`AVMM_ADDR_W-1:0] address;
  logic [`AVMM_DATA_W-1:0] writedata;
  logic                    dcg_en;
  logic                    dcg_cnt_bypass;
  logic [`DCG_CNT_W-1:0]   dcg_wait_cnt;
  logic                    te;
  logic [`AVMM_DATA_W-1:0] readdata;
  logic                    readdatavalid;
  logic                    busy;
  logic                    gclk;
  logic [`DCG_CNT_W+3:0]   dcg_testbus;

  entry_t                  stim_q[$];
  logic [`AVMM_DATA_W-1:0] shadow [`AVMM_CSR_DEPTH];
  logic [31:0]             seed;
  bit                      table_ready;
  int                      err_cnt;
  int                      pass_cnt;
  int                      fail_cnt;

  avmm_dcg_top dut_i
  (
    .clk            (clk),
    .rst_n          (rst_n),
    .read           (read),
    .write          (write),
    .address        (address),
    .writedata      (writedata),
    .dcg_en         (dcg_en),
    .dcg_cnt_bypass (dcg_cnt_bypass),
    .dcg_wait_cnt   (dcg_wait_cnt),
    .te             (te),
    .readdata       (readdata),
    .readdatavalid  (readdatavalid),
    .busy           (busy),
    .gclk           (gclk),
    .dcg_testbus    (dcg_testbus)
  );

  // 4 ns period
  always #2 clk = ~clk;

  // ******************************
  // helpers
  // ******************************

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic string op_name(input int op);
    case (op)
      op_write: return "write";
      op_read:  return "read";
      op_idle:  return "idle";
      default:  return "scan";
    endcase
  endfunction

  task automatic flag_error(input string msg);
    $display("FAIL @ %0t ns: %s", $time, msg);
    err_cnt++;
  endtask

  task automatic add_entry(input int op, input int addr, input int cycles, input bit en,
                           input bit byp, input int wcnt, input bit te_v, input int exp);
    entry_t e;
    e = '{op, addr, cycles, en, byp, wcnt, te_v, exp};
    stim_q.push_back(e);
  endtask

  task automatic build_stimulus();
    // fill, then read back with short waits so gating hits between accesses
    for (int a = 0; a < `AVMM_CSR_DEPTH; a++)
      add_entry(op_write, a, 0, 1'b1, 1'b0, 0, 1'b0, 0);
    for (int a = 0; a < `AVMM_CSR_DEPTH; a++)
      add_entry(op_read, a, 0, 1'b1, 1'b0, a % 4, 1'b0, 2);
    // gate delay is wait + 1 cycles
    add_entry(op_idle, 3, 20, 1'b1, 1'b0, 0, 1'b0, 1);
    add_entry(op_idle, 5, 20, 1'b1, 1'b0, 5, 1'b0, 6);
    add_entry(op_idle, 7, 30, 1'b1, 1'b0, 15, 1'b0, 16);
    // still gated here
    add_entry(op_scan, 0, 6, 1'b1, 1'b0, 15, 1'b0, 0);
    add_entry(op_scan, 0, 6, 1'b1, 1'b0, 15, 1'b1, 0);
    add_entry(op_read, 7, 0, 1'b1, 1'b0, 15, 1'b0, 2);
    // bypass gates on the first idle cycle
    add_entry(op_idle, 9, 20, 1'b1, 1'b1, 9, 1'b0, 1);
    add_entry(op_read, 9, 0, 1'b1, 1'b1, 9, 1'b0, 2);
    // disabled, 0 means never gated
    add_entry(op_idle, 11, 40, 1'b0, 1'b0, 0, 1'b0, 0);
    add_entry(op_read, 11, 0, 1'b1, 1'b0, 3, 1'b0, 2);
    add_entry(op_read, 5, 0, 1'b1, 1'b0, 3, 1'b0, 2);
    add_entry(op_read, 3, 0, 1'b1, 1'b0, 3, 1'b0, 2);
  endtask

  // one strobe, then watch busy and readdatavalid cycle by cycle
  // j counts clk edges after the strobe edge
  task automatic run_access(input bit wr, input int addr, input logic [31:0] wdata,
                            output int rdv_at, output int busy_at, output bit woke,
                            output logic [31:0] rdata);
    rdv_at  = -1;
    busy_at = -1;
    woke    = 1'b0;
    rdata   = '0;
    read      = ~wr;
    write     = wr;
    address   = addr[`AVMM_ADDR_W-1:0];
    writedata = wdata;
    @(negedge clk);
    read  = 1'b0;
    write = 1'b0;
    for (int j = 0; j < 10; j++)
    begin
      if (readdatavalid && rdv_at < 0)
      begin
        rdv_at = j;
        rdata  = readdata;
      end
      if (!busy && busy_at < 0)
        busy_at = j;
      // wake up must be in the cycle after the strobe
      if (j == 1)
        woke = (dcg_testbus[st_bit] == 1'b0);
      if (busy_at >= 0 && (wr || rdv_at >= 0))
        break;
      @(negedge clk);
    end
  endtask

  // k counts edges after busy fell, gclk sampled in the high phase
  task automatic measure_gating(input int cycles, output int first, output int gclk_errs);
    bit prev_st;
    bit st;
    first     = 0;
    gclk_errs = 0;
    prev_st   = dcg_testbus[st_bit];
    for (int k = 1; k <= cycles; k++)
    begin
      @(posedge clk);
      #1;
      // latch holds the enable from the last low phase
      if (gclk !== ~prev_st)
        gclk_errs++;
      @(negedge clk);
      st = dcg_testbus[st_bit];
      if (st && first == 0)
        first = k;
      prev_st = st;
    end
  endtask

  task automatic check_scan(input int cycles, input bit scan_te);
    if (dcg_testbus[st_bit] !== 1'b1)
      $display("scan check started while the DCG block was not gated");
    if (dcg_testbus[st_bit] !== 1'b1)
      err_cnt++;
    for (int k = 0; k < cycles; k++)
    begin
      @(posedge clk);
      #1;
      if (gclk !== scan_te)
        flag_error($sformatf("gclk %b in high phase, te %b", gclk, scan_te));
      @(negedge clk);
      #1;
      if (gclk !== 1'b0)
        flag_error("gclk high in low phase");
      if (dcg_testbus[st_bit] !== 1'b1)
        flag_error("DCG left GATED during scan check");
    end
    @(negedge clk);
  endtask

  // ******************************
  // main sequence
  // ******************************

  initial
  begin
    entry_t      ent;
    int          err_before;
    int          rdv_at;
    int          busy_at;
    int          first;
    int          gclk_errs;
    bit          woke;
    bit          wr;
    logic [31:0] wdata;
    logic [31:0] rdata;
    clk            = 1'b0;
    rst_n          = 1'b0;
    read           = 1'b0;
    write          = 1'b0;
    address        = '0;
    writedata      = '0;
    dcg_en         = 1'b0;
    dcg_cnt_bypass = 1'b0;
    dcg_wait_cnt   = '0;
    te             = 1'b0;
    seed           = 32'd72;
    for (int i = 0; i < `AVMM_CSR_DEPTH; i++)
      shadow[i] = '0;
    build_stimulus();
    table_ready = 1'b1;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    foreach (stim_q[n])
    begin
      ent            = stim_q[n];
      err_before     = err_cnt;
      dcg_en         = ent.en;
      dcg_cnt_bypass = ent.byp;
      dcg_wait_cnt   = ent.wcnt[`DCG_CNT_W-1:0];
      te             = ent.te;
      if (ent.op == op_scan)
      begin
        check_scan(ent.cycles, ent.te);
      end
      else
      begin
        wr    = (ent.op != op_read);
        seed  = lcg_next(seed);
        wdata = wr ? seed : '0;
        run_access(wr, ent.addr, wdata, rdv_at, busy_at, woke, rdata);
        if (busy_at != 2)
          flag_error($sformatf("busy low after %0d cycles, expected 2", busy_at));
        if (!woke)
          flag_error("DCG state still GATED in the cycle after the strobe");
        if (wr)
          shadow[ent.addr] = wdata;
        if (!wr && rdv_at != ent.exp)
          flag_error($sformatf("readdatavalid after %0d cycles, expected %0d",
                               rdv_at, ent.exp));
        if (!wr && rdata !== shadow[ent.addr])
          flag_error($sformatf("addr %0d read %h, expected %h",
                               ent.addr, rdata, shadow[ent.addr]));
        if (ent.op == op_idle)
        begin
          measure_gating(ent.cycles, first, gclk_errs);
          if (first != ent.exp)
            flag_error($sformatf("gated after %0d idle cycles, expected %0d",
                                 first, ent.exp));
          if (gclk_errs != 0)
            flag_error($sformatf("gclk wrong in %0d high phases", gclk_errs));
        end
      end
      if (err_cnt == err_before)
        pass_cnt++;
      else
        fail_cnt++;
      $display("test %0d %s addr %0d: %s", n, op_name(ent.op), ent.addr,
               (err_cnt == err_before) ? "ok" : "failed");
    end

    $display("tests %0d, passed %0d, failed %0d, errors %0d, assertion failures %0d",
             stim_q.size(), pass_cnt, fail_cnt, err_cnt, dut_i.u_checks.assert_errs);
    if (fail_cnt == 0 && err_cnt == 0 && dut_i.u_checks.assert_errs == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

  // budget from the table plus reset and margin
  initial
  begin
    int budget;
    budget = 0;
    wait (table_ready);
    foreach (stim_q[n])
      budget += stim_q[n].cycles + 16;
    #((budget + 20) * 4);
    $display("watchdog expired after %0d cycles, the run did not finish", budget + 20);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

//--- sim.f
+incdir+.
avmm_dcg_pkg.sv
avmm_req_if.sv
avmm_req_capture.sv
avmmclk_dcg.sv
avmm_csr_bank.sv
avmm_resp_drive.sv
avmm_dcg_top.sv
avmm_dcg_assertions.sv
tb_avmm_dcg.sv

//--- Bender.yml
package:
  name: avmm_dcg

sources:
  - include_dirs:
      - .
    files:
      - avmm_dcg_pkg.sv
      - avmm_req_if.sv
      - avmm_req_capture.sv
      - avmmclk_dcg.sv
      - avmm_csr_bank.sv
      - avmm_resp_drive.sv
      - avmm_dcg_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - avmm_dcg_assertions.sv
      - tb_avmm_dcg.sv
